// File: Makefile
TOP := tb_mini_soc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module mini_soc

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: boot_ctrl_slave.sv
// boot controller: core start address register and timed core restart pulse
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl_slave #(
  parameter logic [soc_bus_pkg::ADDR_W-1:0] DEFAULT_BOOT_ADDR = 32'h1000_0000,
  parameter int                             RST_CYCLES        = 4
) (
  input  wire logic                           clk,
  input  wire logic                           rst_i,
  soc_bus_if.slave                            bus,
  output logic      [soc_bus_pkg::ADDR_W-1:0] boot_addr_o,
  output logic                                cpu_rst_o
);

  localparam int CNT_W = $clog2(RST_CYCLES + 1);

  logic [soc_bus_pkg::ADDR_W-1:0] boot_vec_q;
  // cycles of core reset still to go
  logic [CNT_W-1:0]               rst_cnt_q;
  logic                           restart_busy;
  logic                           wr_en;

  assign wr_en        = bus.req && (bus.op == soc_bus_pkg::BUS_WRITE);
  assign restart_busy = (rst_cnt_q != '0);

  // control registers
  // reset also restarts the core, so the counter is loaded too
  always_ff @(posedge clk) begin
    if (rst_i) begin
      boot_vec_q <= DEFAULT_BOOT_ADDR;
      rst_cnt_q  <= CNT_W'(RST_CYCLES);
      bus.ack    <= 1'b0;
    end else begin
      bus.ack <= bus.req;
      if (wr_en && (bus.addr == soc_map_pkg::BOOT_VEC_OFFS)) begin
        boot_vec_q <= bus.wdata;
      end
      // any value written restarts, a new write reloads
      if (wr_en && (bus.addr == soc_map_pkg::BOOT_RESTART_OFFS)) begin
        rst_cnt_q <= CNT_W'(RST_CYCLES);
      end else if (restart_busy) begin
        rst_cnt_q <= rst_cnt_q - 1'b1;
      end
    end
  end

  // readback
  always_ff @(posedge clk) begin
    if (bus.req && (bus.op == soc_bus_pkg::BUS_READ)) begin
      case (bus.addr)
        soc_map_pkg::BOOT_VEC_OFFS:     bus.rdata <= boot_vec_q;
        soc_map_pkg::BOOT_RESTART_OFFS: bus.rdata <= {31'd0, restart_busy};
        default:                        bus.rdata <= '0;
      endcase
    end
  end

  assign boot_addr_o = boot_vec_q;
  // high from the cycle after the write, RST_CYCLES long
  assign cpu_rst_o   = restart_busy;

endmodule

`default_nettype wire

// File: bus_decoder.sv
// address decoder: steers each request to one slave and returns its response or an error
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  wire logic                             clk,
  input  wire logic                             rst_i,
  input  wire logic                             bus_req_i,
  input  wire soc_bus_pkg::bus_op_e             bus_op_i,
  input  wire logic [soc_bus_pkg::ADDR_W-1:0]   bus_addr_i,
  input  wire logic [soc_bus_pkg::DATA_W-1:0]   bus_wdata_i,
  output logic      [soc_bus_pkg::DATA_W-1:0]   bus_rdata_o,
  output logic                                  bus_ack_o,
  output logic                                  bus_err_o,
  soc_bus_if.master                             ram_bus,
  soc_bus_if.master                             boot_bus,
  soc_bus_if.master                             gpio_bus,
  soc_bus_if.master                             tmr_bus
);

  soc_map_pkg::slave_idx_e region;
  logic                    mapped;

  // steering state for the response cycle
  soc_map_pkg::slave_idx_e sel_q;
  logic                    unmapped_q;

  // region nibble of the incoming address
  assign region = soc_map_pkg::slave_idx_e'(
    bus_addr_i[soc_map_pkg::REGION_MSB:soc_map_pkg::REGION_LSB]);

  always_comb begin
    case (region)
      soc_map_pkg::SLV_RAM,
      soc_map_pkg::SLV_BOOT,
      soc_map_pkg::SLV_GPIO,
      soc_map_pkg::SLV_MTIMER: mapped = 1'b1;
      default:                 mapped = 1'b0;
    endcase
  end

  // strobe only to the selected slave, rest is broadcast
  assign ram_bus.req    = bus_req_i && (region == soc_map_pkg::SLV_RAM);
  assign ram_bus.op     = bus_op_i;
  assign ram_bus.addr   = bus_addr_i[soc_bus_pkg::OFFS_W-1:0];
  assign ram_bus.wdata  = bus_wdata_i;

  assign boot_bus.req   = bus_req_i && (region == soc_map_pkg::SLV_BOOT);
  assign boot_bus.op    = bus_op_i;
  assign boot_bus.addr  = bus_addr_i[soc_bus_pkg::OFFS_W-1:0];
  assign boot_bus.wdata = bus_wdata_i;

  assign gpio_bus.req   = bus_req_i && (region == soc_map_pkg::SLV_GPIO);
  assign gpio_bus.op    = bus_op_i;
  assign gpio_bus.addr  = bus_addr_i[soc_bus_pkg::OFFS_W-1:0];
  assign gpio_bus.wdata = bus_wdata_i;

  assign tmr_bus.req    = bus_req_i && (region == soc_map_pkg::SLV_MTIMER);
  assign tmr_bus.op     = bus_op_i;
  assign tmr_bus.addr   = bus_addr_i[soc_bus_pkg::OFFS_W-1:0];
  assign tmr_bus.wdata  = bus_wdata_i;

  // remember who answers next cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sel_q      <= soc_map_pkg::SLV_RAM;
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= bus_req_i && !mapped;
      if (bus_req_i && mapped) begin
        sel_q <= region;
      end
    end
  end

  // response mux, unmapped requests get a local ack with err
  always_comb begin
    bus_rdata_o = '0;
    bus_ack_o   = unmapped_q;
    bus_err_o   = unmapped_q;
    if (!unmapped_q) begin
      case (sel_q)
        soc_map_pkg::SLV_RAM: begin
          bus_rdata_o = ram_bus.rdata;
          bus_ack_o   = ram_bus.ack;
        end
        soc_map_pkg::SLV_BOOT: begin
          bus_rdata_o = boot_bus.rdata;
          bus_ack_o   = boot_bus.ack;
        end
        soc_map_pkg::SLV_GPIO: begin
          bus_rdata_o = gpio_bus.rdata;
          bus_ack_o   = gpio_bus.ack;
        end
        soc_map_pkg::SLV_MTIMER: begin
          bus_rdata_o = tmr_bus.rdata;
          bus_ack_o   = tmr_bus.ack;
        end
        default: begin
          bus_rdata_o = '0;
          bus_ack_o   = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: gpio_csr_slave.sv
// gpio block: 8-bit control output register and synchronized input readback
`timescale 1ns/1ps
`default_nettype none

module gpio_csr_slave (
  input  wire logic       clk,
  input  wire logic       rst_i,
  soc_bus_if.slave        bus,
  input  wire logic [7:0] gpio_in_i,
  output logic      [7:0] csr_o
);

  logic [7:0] csr_q;
  // two-flop synchronizer for the async pins
  logic [7:0] in_meta_q;
  logic [7:0] in_sync_q;

  always_ff @(posedge clk) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // control register, input offset is read only
  always_ff @(posedge clk) begin
    if (rst_i) begin
      csr_q   <= '0;
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.req;
      if (bus.req && (bus.op == soc_bus_pkg::BUS_WRITE) &&
          (bus.addr == soc_map_pkg::GPIO_CSR_OFFS)) begin
        csr_q <= bus.wdata[7:0];
      end
    end
  end

  // zero-extended readback
  always_ff @(posedge clk) begin
    if (bus.req && (bus.op == soc_bus_pkg::BUS_READ)) begin
      case (bus.addr)
        soc_map_pkg::GPIO_CSR_OFFS: bus.rdata <= {24'd0, csr_q};
        soc_map_pkg::GPIO_IN_OFFS:  bus.rdata <= {24'd0, in_sync_q};
        default:                    bus.rdata <= '0;
      endcase
    end
  end

  assign csr_o = csr_q;

endmodule

`default_nettype wire

// File: mini_soc.sv
// peripheral subsystem top: decoder plus ram, boot, gpio and timer slaves
`timescale 1ns/1ps
`default_nettype none

module mini_soc #(
  parameter int                             MEM_WORDS         = 256,
  parameter int                             RST_CYCLES        = 4,
  parameter logic [soc_bus_pkg::ADDR_W-1:0] DEFAULT_BOOT_ADDR = 32'h1000_0000
) (
  input  wire logic                             clk,
  input  wire logic                             rst_i,
  // external master, single beat
  input  wire logic                             bus_req_i,
  input  wire soc_bus_pkg::bus_op_e             bus_op_i,
  input  wire logic [soc_bus_pkg::ADDR_W-1:0]   bus_addr_i,
  input  wire logic [soc_bus_pkg::DATA_W-1:0]   bus_wdata_i,
  output logic      [soc_bus_pkg::DATA_W-1:0]   bus_rdata_o,
  output logic                                  bus_ack_o,
  output logic                                  bus_err_o,
  // gpio pins
  input  wire logic [7:0]                       gpio_in_i,
  output logic      [7:0]                       csr_o,
  // core control
  output logic      [soc_bus_pkg::ADDR_W-1:0]   boot_addr_o,
  output logic                                  cpu_rst_o,
  output logic                                  mtimer_irq_o
);

  // one bus per slave
  soc_bus_if ram_bus  ();
  soc_bus_if boot_bus ();
  soc_bus_if gpio_bus ();
  soc_bus_if tmr_bus  ();

  bus_decoder u_bus_decoder (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_op_i    (bus_op_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rdata_o (bus_rdata_o),
    .bus_ack_o   (bus_ack_o),
    .bus_err_o   (bus_err_o),
    .ram_bus     (ram_bus.master),
    .boot_bus    (boot_bus.master),
    .gpio_bus    (gpio_bus.master),
    .tmr_bus     (tmr_bus.master)
  );

  // region 0x1
  sram_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .clk (clk),
    .bus (ram_bus.slave)
  );

  // region 0xC
  boot_ctrl_slave #(
    .DEFAULT_BOOT_ADDR (DEFAULT_BOOT_ADDR),
    .RST_CYCLES        (RST_CYCLES)
  ) u_boot_ctrl (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus         (boot_bus.slave),
    .boot_addr_o (boot_addr_o),
    .cpu_rst_o   (cpu_rst_o)
  );

  // region 0xD
  gpio_csr_slave u_gpio (
    .clk       (clk),
    .rst_i     (rst_i),
    .bus       (gpio_bus.slave),
    .gpio_in_i (gpio_in_i),
    .csr_o     (csr_o)
  );

  // region 0xF
  mtimer_slave u_mtimer (
    .clk          (clk),
    .rst_i        (rst_i),
    .bus          (tmr_bus.slave),
    .mtimer_irq_o (mtimer_irq_o)
  );

endmodule

`default_nettype wire

// File: mtimer_slave.sv
// machine timer: free-running counter, compare register and level interrupt
`timescale 1ns/1ps
`default_nettype none

module mtimer_slave (
  input  wire logic clk,
  input  wire logic rst_i,
  soc_bus_if.slave  bus,
  output logic      mtimer_irq_o
);

  logic [soc_bus_pkg::DATA_W-1:0] mtime_q;
  logic [soc_bus_pkg::DATA_W-1:0] mtimecmp_q;
  logic                           irq_q;
  logic                           wr_mtime;
  logic                           wr_mtimecmp;

  assign wr_mtime    = bus.req && (bus.op == soc_bus_pkg::BUS_WRITE) &&
                       (bus.addr == soc_map_pkg::MTIME_OFFS);
  assign wr_mtimecmp = bus.req && (bus.op == soc_bus_pkg::BUS_WRITE) &&
                       (bus.addr == soc_map_pkg::MTIMECMP_OFFS);

  // counter, a write wins over the increment
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (wr_mtime) begin
      mtime_q <= bus.wdata;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // compare starts at max so no irq out of reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mtimecmp_q <= '1;
    end else if (wr_mtimecmp) begin
      mtimecmp_q <= bus.wdata;
    end
  end

  // level irq, one cycle behind the compare
  // software clears it by moving mtimecmp above mtime
  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q   <= 1'b0;
      bus.ack <= 1'b0;
    end else begin
      irq_q   <= (mtime_q >= mtimecmp_q);
      bus.ack <= bus.req;
    end
  end

  // readback, mtime as seen on the sampling edge
  always_ff @(posedge clk) begin
    if (bus.req && (bus.op == soc_bus_pkg::BUS_READ)) begin
      case (bus.addr)
        soc_map_pkg::MTIME_OFFS:    bus.rdata <= mtime_q;
        soc_map_pkg::MTIMECMP_OFFS: bus.rdata <= mtimecmp_q;
        default:                    bus.rdata <= '0;
      endcase
    end
  end

  assign mtimer_irq_o = irq_q;

endmodule

`default_nettype wire

// File: soc_bus_if.sv
// single-beat request/response bus between the decoder and one slave
`timescale 1ns/1ps
`default_nettype none

interface soc_bus_if;

  // one-cycle request strobe
  logic                              req;
  soc_bus_pkg::bus_op_e              op;
  // offset inside the region, region bits already stripped
  logic [soc_bus_pkg::OFFS_W-1:0]    addr;
  logic [soc_bus_pkg::DATA_W-1:0]    wdata;

  // response, valid the cycle after req
  logic [soc_bus_pkg::DATA_W-1:0]    rdata;
  logic                              ack;

  // decoder side
  modport master (
    output req, op, addr, wdata,
    input  rdata, ack
  );

  // peripheral side
  modport slave (
    input  req, op, addr, wdata,
    output rdata, ack
  );

endinterface

`default_nettype wire

// File: soc_bus_pkg.sv
// bus package: widths and operation codes for the single-beat peripheral bus
`default_nettype none

package soc_bus_pkg;

  // full address as issued by the external master
  localparam int ADDR_W = 32;

  // one data word per beat
  localparam int DATA_W = 32;

  // offset inside a 4 KB region, all a slave ever sees
  localparam int OFFS_W = 12;

  // operation carried with every request strobe
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

endpackage

`default_nettype wire

// File: soc_map_pkg.sv
// address map package: region field, slave regions and register offsets
`default_nettype none

package soc_map_pkg;

  // region nibble at the top of the address
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  // mapped regions, value is the region nibble itself
  typedef enum logic [3:0] {
    SLV_RAM    = 4'd1,
    SLV_BOOT   = 4'd12,
    SLV_GPIO   = 4'd13,
    SLV_MTIMER = 4'd15
  } slave_idx_e;

  // boot controller registers
  localparam logic [soc_bus_pkg::OFFS_W-1:0] BOOT_VEC_OFFS     = 12'h000;
  localparam logic [soc_bus_pkg::OFFS_W-1:0] BOOT_RESTART_OFFS = 12'h004;

  // gpio registers
  localparam logic [soc_bus_pkg::OFFS_W-1:0] GPIO_CSR_OFFS = 12'h000;
  localparam logic [soc_bus_pkg::OFFS_W-1:0] GPIO_IN_OFFS  = 12'h004;

  // machine timer registers
  localparam logic [soc_bus_pkg::OFFS_W-1:0] MTIME_OFFS    = 12'h000;
  localparam logic [soc_bus_pkg::OFFS_W-1:0] MTIMECMP_OFFS = 12'h004;

endpackage

`default_nettype wire

// File: sources.f
soc_bus_pkg.sv
soc_map_pkg.sv
soc_bus_if.sv
bus_decoder.sv
sram_slave.sv
boot_ctrl_slave.sv
gpio_csr_slave.sv
mtimer_slave.sv
mini_soc.sv
tb_mini_soc.sv

// File: sram_slave.sv
// single-port word RAM slave with read data registered alongside the ack
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
  parameter int MEM_WORDS = 256
) (
  input  wire logic clk,
  soc_bus_if.slave  bus
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [soc_bus_pkg::DATA_W-1:0] mem [MEM_WORDS];

  // word part of the byte offset
  logic [soc_bus_pkg::OFFS_W-3:0] word_off;
  logic [IDX_W-1:0]               mem_idx;

  assign word_off = bus.addr[soc_bus_pkg::OFFS_W-1:2];
  // wraps when the region is larger than the array
  assign mem_idx  = IDX_W'(32'(word_off) % MEM_WORDS);

  // ack follows req by one cycle
  always_ff @(posedge clk) begin
    bus.ack <= bus.req;
  end

  // array and read port
  always_ff @(posedge clk) begin
    if (bus.req) begin
      if (bus.op == soc_bus_pkg::BUS_WRITE) begin
        mem[mem_idx] <= bus.wdata;
      end else begin
        bus.rdata <= mem[mem_idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_mini_soc.sv
// testbench for the peripheral subsystem: bus traffic to every slave checked against a shadow model
`timescale 1ns/1ps
`default_nettype none

module tb_mini_soc;

  localparam int          MEM_WORDS   = 256;
  localparam int          RST_CYCLES  = 4;
  localparam logic [31:0] BOOT_RESET  = 32'h1000_0000;
  // all tests take a few hundred cycles
  localparam int          CYCLE_LIMIT = 3000;
  // idle cycles between the two mtime reads
  localparam int          GAP         = 10;

  logic                 clk = 1'b0;
  logic                 rst_i;
  logic                 bus_req_i;
  soc_bus_pkg::bus_op_e bus_op_i;
  logic [31:0]          bus_addr_i;
  logic [31:0]          bus_wdata_i;
  logic [31:0]          bus_rdata_o;
  logic                 bus_ack_o;
  logic                 bus_err_o;
  logic [7:0]           gpio_in_i;
  logic [7:0]           csr_o;
  logic [31:0]          boot_addr_o;
  logic                 cpu_rst_o;
  logic                 mtimer_irq_o;

  // shadow model of every readable register
  logic [31:0] shadow_ram [MEM_WORDS];
  logic        ram_written [MEM_WORDS];
  logic [31:0] shadow_vec = BOOT_RESET;
  logic [7:0]  shadow_csr = 8'h00;
  logic [7:0]  shadow_gpio_in = 8'h00;
  logic [31:0] shadow_cmp = '1;

  // request seen in the previous cycle
  logic        pend_req = 1'b0;
  logic        pend_rd;
  logic        pend_known;
  logic        pend_err;
  logic [31:0] pend_exp;

  logic [31:0] lfsr_q = 32'hc480_19a1;
  int          cycle_cnt = 0;
  int          reads_checked = 0;
  string       test_name = "reset";

  mini_soc u_dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .bus_req_i    (bus_req_i),
    .bus_op_i     (bus_op_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rdata_o  (bus_rdata_o),
    .bus_ack_o    (bus_ack_o),
    .bus_err_o    (bus_err_o),
    .gpio_in_i    (gpio_in_i),
    .csr_o        (csr_o),
    .boot_addr_o  (boot_addr_o),
    .cpu_rst_o    (cpu_rst_o),
    .mtimer_irq_o (mtimer_irq_o)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic require(input logic cond, input string msg);
    assert (cond) else fail_run($sformatf("%s in test %s", msg, test_name));
  endtask

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      fail_run($sformatf("mismatch %s %s exp=%h act=%h", test_name, what, exp, act));
  endtask

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [31:0] make_addr(input logic [3:0] nib, input logic [11:0] offs);
    make_addr = {nib, 16'h0000, offs};
  endfunction

  // expected read data, known low where the value moves with time
  function automatic logic [31:0] ref_read(input logic [31:0] addr, output logic known,
                                           output logic err);
    logic [11:0] offs;
    int          idx;
    offs     = addr[11:0];
    idx      = int'(addr[11:2]) % MEM_WORDS;
    known    = 1'b1;
    err      = 1'b0;
    ref_read = '0;
    case (addr[31:28])
      soc_map_pkg::SLV_RAM: begin
        known    = ram_written[idx];
        ref_read = shadow_ram[idx];
      end
      soc_map_pkg::SLV_BOOT: begin
        ref_read = (offs == soc_map_pkg::BOOT_VEC_OFFS) ? shadow_vec : '0;
        known    = (offs != soc_map_pkg::BOOT_RESTART_OFFS);
      end
      soc_map_pkg::SLV_GPIO: begin
        if (offs == soc_map_pkg::GPIO_CSR_OFFS) begin
          ref_read = {24'd0, shadow_csr};
        end else if (offs == soc_map_pkg::GPIO_IN_OFFS) begin
          ref_read = {24'd0, shadow_gpio_in};
        end
      end
      soc_map_pkg::SLV_MTIMER: begin
        ref_read = (offs == soc_map_pkg::MTIMECMP_OFFS) ? shadow_cmp : '0;
        // mtime is checked by deltas in its own test
        known    = (offs != soc_map_pkg::MTIME_OFFS);
      end
      default: begin
        err = 1'b1;
      end
    endcase
  endfunction

  // shadow follows writes in request order
  function automatic void write_shadow(input logic [31:0] addr, input logic [31:0] data);
    int idx;
    idx = int'(addr[11:2]) % MEM_WORDS;
    case (addr[31:28])
      soc_map_pkg::SLV_RAM: begin
        shadow_ram[idx]  = data;
        ram_written[idx] = 1'b1;
      end
      soc_map_pkg::SLV_BOOT: begin
        if (addr[11:0] == soc_map_pkg::BOOT_VEC_OFFS) begin
          shadow_vec = data;
        end
      end
      soc_map_pkg::SLV_GPIO: begin
        if (addr[11:0] == soc_map_pkg::GPIO_CSR_OFFS) begin
          shadow_csr = data[7:0];
        end
      end
      soc_map_pkg::SLV_MTIMER: begin
        if (addr[11:0] == soc_map_pkg::MTIMECMP_OFFS) begin
          shadow_cmp = data;
        end
      end
      default: begin
      end
    endcase
  endfunction

  // response checker, samples mid-cycle
  // request seen here must be acked at the next negedge
  always @(negedge clk) begin
    if (rst_i) begin
      pend_req = 1'b0;
    end else begin
      if (pend_req) begin
        require(bus_ack_o === 1'b1, "ack missing one cycle after a request");
        expect_eq("bus_err_o", {31'd0, pend_err}, {31'd0, bus_err_o});
        if (pend_rd && pend_known) begin
          expect_eq("bus_rdata_o", pend_exp, bus_rdata_o);
          reads_checked++;
        end
      end else begin
        require(bus_ack_o === 1'b0, "ack seen without a request");
      end
      pend_req = bus_req_i;
      pend_rd  = (bus_op_i == soc_bus_pkg::BUS_READ);
      pend_exp = ref_read(bus_addr_i, pend_known, pend_err);
      if (bus_req_i && !pend_rd) begin
        write_shadow(bus_addr_i, bus_wdata_i);
      end
    end
  end

  // run length guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout after %0d cycles in test %s", cycle_cnt, test_name));
    end
  end

  // inputs change 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic set_req(input soc_bus_pkg::bus_op_e op, input logic [31:0] addr,
                         input logic [31:0] data);
    bus_req_i   = 1'b1;
    bus_op_i    = op;
    bus_addr_i  = addr;
    bus_wdata_i = data;
  endtask

  task automatic drop_req();
    bus_req_i = 1'b0;
  endtask

  // one request cycle, leaves req up for back-to-back use
  task automatic issue_req(input soc_bus_pkg::bus_op_e op, input logic [31:0] addr,
                           input logic [31:0] data);
    set_req(op, addr, data);
    next_cycle();
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic ack, output logic err);
    issue_req(soc_bus_pkg::BUS_WRITE, addr, data);
    drop_req();
    @(negedge clk);
    ack = bus_ack_o;
    err = bus_err_o;
    next_cycle();
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic ack, output logic err,
                          output logic [31:0] data);
    issue_req(soc_bus_pkg::BUS_READ, addr, 32'd0);
    drop_req();
    @(negedge clk);
    ack  = bus_ack_o;
    err  = bus_err_o;
    data = bus_rdata_o;
    next_cycle();
  endtask

  // cpu_rst_o high at the next RST_CYCLES negedges, then low
  task automatic rst_pulse_check();
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(negedge clk);
      require(cpu_rst_o === 1'b1, $sformatf("cpu_rst_o low in pulse cycle %0d", i));
    end
    @(negedge clk);
    require(cpu_rst_o === 1'b0, "cpu_rst_o still high after the pulse");
  endtask

  task automatic ram_random_rw();
    logic [7:0]  idx [64];
    logic [31:0] v;
    int          start;
    test_name = "ram_random";
    start     = reads_checked;
    for (int i = 0; i < 64; i++) begin
      take_bits(8, v);
      idx[i] = v[7:0];
      take_bits(32, v);
      issue_req(soc_bus_pkg::BUS_WRITE, make_addr(soc_map_pkg::SLV_RAM, {2'b00, idx[i], 2'b00}), v);
    end
    for (int i = 0; i < 64; i++) begin
      issue_req(soc_bus_pkg::BUS_READ, make_addr(soc_map_pkg::SLV_RAM, {2'b00, idx[i], 2'b00}), 0);
    end
    drop_req();
    next_cycle();
    require((reads_checked - start) == 64, "not every ram read was compared");
  endtask

  task automatic unmapped_regions();
    logic [3:0]  nibs [3];
    logic [31:0] addr;
    logic [31:0] rd;
    logic        ack;
    logic        err;
    test_name = "unmapped";
    nibs[0]   = 4'h0;
    nibs[1]   = 4'h2;
    nibs[2]   = 4'he;
    for (int i = 0; i < 3; i++) begin
      take_bits(12, addr);
      addr = make_addr(nibs[i], addr[11:0]);
      bus_write(addr, 32'hdead_beef, ack, err);
      require(ack && err, "unmapped write not answered with err");
      bus_read(addr, ack, err, rd);
      require(ack && err, "unmapped read not answered with err");
      expect_eq("unmapped rdata", 32'd0, rd);
    end
  endtask

  task automatic gpio_out_in();
    logic [31:0] v;
    logic [31:0] rd;
    logic        ack;
    logic        err;
    test_name = "gpio";
    expect_eq("csr_o after reset", 32'd0, {24'd0, csr_o});
    take_bits(8, v);
    bus_write(make_addr(soc_map_pkg::SLV_GPIO, soc_map_pkg::GPIO_CSR_OFFS), v, ack, err);
    expect_eq("csr_o", {24'd0, v[7:0]}, {24'd0, csr_o});
    bus_read(make_addr(soc_map_pkg::SLV_GPIO, soc_map_pkg::GPIO_CSR_OFFS), ack, err, rd);
    expect_eq("csr readback", {24'd0, v[7:0]}, rd);
    // pins held long enough to cross the synchronizer
    take_bits(8, v);
    gpio_in_i      = v[7:0];
    shadow_gpio_in = v[7:0];
    repeat (4) next_cycle();
    bus_read(make_addr(soc_map_pkg::SLV_GPIO, soc_map_pkg::GPIO_IN_OFFS), ack, err, rd);
    expect_eq("gpio_in readback", {24'd0, v[7:0]}, rd);
  endtask

  task automatic boot_restart_seq();
    logic [31:0] v;
    logic [31:0] rd;
    logic        ack;
    logic        err;
    test_name = "boot_restart";
    expect_eq("boot_addr_o after reset", BOOT_RESET, boot_addr_o);
    take_bits(32, v);
    bus_write(make_addr(soc_map_pkg::SLV_BOOT, soc_map_pkg::BOOT_VEC_OFFS), v, ack, err);
    expect_eq("boot_addr_o", v, boot_addr_o);
    bus_read(make_addr(soc_map_pkg::SLV_BOOT, soc_map_pkg::BOOT_VEC_OFFS), ack, err, rd);
    expect_eq("boot vector readback", v, rd);
    // pulse starts the cycle after the request
    set_req(soc_bus_pkg::BUS_WRITE,
            make_addr(soc_map_pkg::SLV_BOOT, soc_map_pkg::BOOT_RESTART_OFFS), v);
    @(negedge clk);
    require(cpu_rst_o === 1'b0, "cpu_rst_o high during the restart request cycle");
    next_cycle();
    drop_req();
    rst_pulse_check();
    next_cycle();
  endtask

  task automatic mtimer_irq_seq();
    logic [31:0] d0;
    logic [31:0] d1;
    logic        ack;
    logic        err;
    test_name = "mtimer";
    require(mtimer_irq_o === 1'b0, "mtimer_irq_o high after reset");
    bus_write(make_addr(soc_map_pkg::SLV_MTIMER, soc_map_pkg::MTIME_OFFS), 32'd0, ack, err);
    bus_write(make_addr(soc_map_pkg::SLV_MTIMER, soc_map_pkg::MTIMECMP_OFFS), 32'd100, ack, err);
    // about 50 cycles after the mtime write
    repeat (46) next_cycle();
    require(mtimer_irq_o === 1'b0, "mtimer_irq_o high before mtime reached mtimecmp");
    // about 120 cycles after the mtime write
    repeat (70) next_cycle();
    require(mtimer_irq_o === 1'b1, "mtimer_irq_o low after mtime passed mtimecmp");
    bus_write(make_addr(soc_map_pkg::SLV_MTIMER, soc_map_pkg::MTIMECMP_OFFS), '1, ack, err);
    require(mtimer_irq_o === 1'b0, "mtimer_irq_o still high after raising mtimecmp");
    bus_read(make_addr(soc_map_pkg::SLV_MTIMER, soc_map_pkg::MTIMECMP_OFFS), ack, err, d0);
    // each read spans two edges, so request edges are GAP + 2 apart
    bus_read(make_addr(soc_map_pkg::SLV_MTIMER, soc_map_pkg::MTIME_OFFS), ack, err, d0);
    repeat (GAP) next_cycle();
    bus_read(make_addr(soc_map_pkg::SLV_MTIMER, soc_map_pkg::MTIME_OFFS), ack, err, d1);
    expect_eq("mtime delta", GAP + 2, d1 - d0);
  endtask

  initial begin
    foreach (ram_written[i]) begin
      ram_written[i] = 1'b0;
    end
    rst_i       = 1'b1;
    bus_req_i   = 1'b0;
    bus_op_i    = soc_bus_pkg::BUS_READ;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    gpio_in_i   = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_i = 1'b0;
    // reset also restarts the core
    rst_pulse_check();
    next_cycle();
    ram_random_rw();
    unmapped_regions();
    gpio_out_in();
    boot_restart_seq();
    mtimer_irq_seq();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
